// File: pipeCtrl_defines.svh
/* Widths and memory timing shared by the pipeline control project.
   MEM_WORDS and LINE_BYTES must be powers of two, and MEM_LATENCY at least 1. */
`ifndef PIPECTRL_DEFINES_SVH
`define PIPECTRL_DEFINES_SVH

// byte address width
`define ADDR_WIDTH 32

// word width, a multiple of 8
`define DATA_WIDTH 32

// shared memory depth in words
`define MEM_WORDS 256

// line size for the load-after-store check
`define LINE_BYTES 16

// cycles from start to done
`define MEM_LATENCY 3

`endif

// File: pipeCtrlPkg.sv
/* Types for the pipeline control and memory access ports.
   Widths come from the defines header. */
`default_nettype none

`include "pipeCtrl_defines.svh"

package pipeCtrlPkg;

    // byte address
    typedef logic [`ADDR_WIDTH-1:0] addrT;

    // one memory word
    typedef logic [`DATA_WIDTH-1:0] dataT;

    // index into the word array
    typedef logic [$clog2(`MEM_WORDS)-1:0] wordIdxT;

    // address bits above the line offset
    typedef logic [`ADDR_WIDTH-$clog2(`LINE_BYTES)-1:0] lineTagT;

    // access port FSM
    typedef enum logic [1:0] {
        idle,
        waitGrant,
        inFlight,
        holding
    } portStateT;

    // owner of the access in flight
    typedef enum logic {
        instPort,
        dataPort
    } requesterT;

endpackage

`default_nettype wire

// File: pipeControl.sv
/* Stall and flush resolution for the seven-stage pipeline, purely combinational.
   Sources are resolved by fixed priority; a flushed stage keeps its write enable high. */
`default_nettype none

`include "pipeCtrl_defines.svh"

module pipeControl (
    input  wire                flushException,
    input  wire                iTlbStall,
    input  wire                dTlbStall,
    input  wire                iBusy,
    input  wire                dBusy,
    input  wire                dataHazardStall,
    input  wire                idImmJump,
    input  wire                branchFailed,
    input  wire                mulDivBusy,
    input  wire                memAccessReq,
    input  wire                mem2StoreReq,
    input  wire                wbStoreReq,
    input  wire pipeCtrlPkg::addrT memAddr,
    input  wire pipeCtrlPkg::addrT mem2Addr,
    input  wire pipeCtrlPkg::addrT wbAddr,
    output logic               preIfWr,
    output logic               ifWr,
    output logic               idWr,
    output logic               exeWr,
    output logic               memWr,
    output logic               mem2Wr,
    output logic               wbWr,
    output logic               ifFlush,
    output logic               idFlush,
    output logic               exeFlush,
    output logic               memFlush,
    output logic               mem2Flush,
    output logic               wbFlush,
    output logic               exeDisWr,
    output logic               memDisWr,
    output logic               wbDisWr,
    output logic               iFlush,
    output logic               dFlush,
    output logic               iReqEnable,
    output logic               dReqEnable,
    output logic               iHold,
    output logic               dHold
);
    import pipeCtrlPkg::*;

    localparam int LineOffset = $clog2(`LINE_BYTES);

    lineTagT memTag;
    lineTagT mem2Tag;
    lineTagT wbTag;
    logic    loadStoreConflict;

    assign memTag  = memAddr[`ADDR_WIDTH-1:LineOffset];
    assign mem2Tag = mem2Addr[`ADDR_WIDTH-1:LineOffset];
    assign wbTag   = wbAddr[`ADDR_WIDTH-1:LineOffset];

    // same line as an older store still on its way out
    assign loadStoreConflict = memAccessReq &&
                               ((mem2StoreReq && memTag == mem2Tag) ||
                                (wbStoreReq && memTag == wbTag));

    always_comb begin
        preIfWr    = 1'b1; // normal flow
        ifWr       = 1'b1;
        idWr       = 1'b1;
        exeWr      = 1'b1;
        memWr      = 1'b1;
        mem2Wr     = 1'b1;
        wbWr       = 1'b1;
        ifFlush    = 1'b0;
        idFlush    = 1'b0;
        exeFlush   = 1'b0;
        memFlush   = 1'b0;
        mem2Flush  = 1'b0;
        wbFlush    = 1'b0;
        exeDisWr   = 1'b0;
        memDisWr   = 1'b0;
        wbDisWr    = 1'b0;
        iFlush     = 1'b0;
        dFlush     = 1'b0;
        iReqEnable = 1'b1;
        dReqEnable = 1'b1;
        iHold      = 1'b0;
        dHold      = 1'b0;

        if (flushException) begin
            ifFlush    = 1'b1; // kill everything before mem2
            idFlush    = 1'b1;
            exeFlush   = 1'b1;
            memFlush   = 1'b1;
            exeDisWr   = 1'b1; // no HI/LO update
            memDisWr   = 1'b1; // no CP0 update
            iFlush     = 1'b1;
            dFlush     = 1'b1;
            iReqEnable = 1'b0;
            dReqEnable = 1'b0;
        end else if (iTlbStall || iBusy) begin
            {preIfWr, ifWr, idWr, exeWr, memWr, mem2Wr, wbWr} = '0;
            {exeDisWr, memDisWr, wbDisWr} = '1;
            iReqEnable = 1'b0;
            iHold      = 1'b1;
            dHold      = 1'b1;
        end else if (dTlbStall || dBusy) begin
            {preIfWr, ifWr, idWr, exeWr, memWr, mem2Wr, wbWr} = '0;
            {exeDisWr, memDisWr, wbDisWr} = '1;
            dReqEnable = 1'b0;
            iHold      = 1'b1;
            dHold      = 1'b1;
        end else if (loadStoreConflict) begin
            {preIfWr, ifWr, idWr, exeWr, memWr} = '0; // let the stores drain
            iReqEnable = 1'b0;
            dReqEnable = 1'b0;
            iHold      = 1'b1;
            dHold      = 1'b1;
        end else if (dataHazardStall) begin
            {preIfWr, ifWr, idWr} = '0;
            exeFlush   = 1'b1; // bubble into execute
            iHold      = 1'b1;
        end else if (idImmJump) begin
            ifFlush    = 1'b1; // drop the slot after the jump
            iFlush     = 1'b1;
            iReqEnable = 1'b0;
        end else if (branchFailed) begin
            ifFlush    = 1'b1;
            idFlush    = 1'b1;
            iFlush     = 1'b1;
            iReqEnable = 1'b0;
        end else if (mulDivBusy) begin
            {preIfWr, ifWr, idWr, exeWr, memWr, mem2Wr, wbWr} = '0;
            {exeDisWr, memDisWr, wbDisWr} = '1;
            iHold      = 1'b1;
            dHold      = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: accessPort.sv
/* Single-request memory access port; one access at a time, no queueing.
   A flushed access still completes in memory but its result is dropped. */
`default_nettype none

module accessPort (
    input  wire                    clk,
    input  wire                    arstN,
    input  wire                    req,
    input  wire                    we,
    input  wire                    reqEnable,
    input  wire                    flush,
    input  wire                    hold,
    input  wire                    grant,
    input  wire                    respDone,
    input  wire pipeCtrlPkg::addrT addr,
    input  wire pipeCtrlPkg::dataT wdata,
    input  wire pipeCtrlPkg::dataT respData,
    output logic                   memReq,
    output logic                   busy,
    output logic                   valid,
    output pipeCtrlPkg::addrT      memAddr,
    output pipeCtrlPkg::dataT      memWdata,
    output pipeCtrlPkg::dataT      rdata,
    output logic                   memWe
);
    import pipeCtrlPkg::*;

    portStateT state;
    logic      cancel;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state  <= idle;
            cancel <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    cancel <= 1'b0;
                    if (req && reqEnable) state <= waitGrant;
                end
                waitGrant: begin
                    if (grant) begin
                        state  <= inFlight;
                        cancel <= flush; // granted in the flush cycle
                    end else if (flush) begin
                        state  <= idle;
                    end
                end
                inFlight: begin
                    if (flush) cancel <= 1'b1;
                    if (respDone) state <= (cancel || flush) ? idle : holding;
                end
                holding: begin
                    if (flush || !hold) state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (state == idle && req && reqEnable) begin
            memAddr  <= addr;
            memWe    <= we;
            memWdata <= wdata;
        end
        if (state == inFlight && respDone) rdata <= respData;
    end

    assign memReq = (state == waitGrant);
    assign busy   = (state == waitGrant) || (state == inFlight);
    assign valid  = (state == holding) && !flush; // flushed result never shown

    grantOnlyWhenWaiting: assert property (@(posedge clk) disable iff (!arstN)
        grant |-> state == waitGrant);

endmodule

`default_nettype wire

// File: memArbiter.sv
/* Fixed-priority arbiter for the shared memory, data port ahead of instruction port.
   Grants only while memory is idle, so at most one access is in flight. */
`default_nettype none

module memArbiter (
    input  wire                    clk,
    input  wire                    arstN,
    input  wire                    iMemReq,
    input  wire                    dMemReq,
    input  wire                    memBusy,
    input  wire                    memDone,
    input  wire                    iWe,
    input  wire                    dWe,
    input  wire pipeCtrlPkg::addrT iAddr,
    input  wire pipeCtrlPkg::addrT dAddr,
    input  wire pipeCtrlPkg::dataT iWdata,
    input  wire pipeCtrlPkg::dataT dWdata,
    input  wire pipeCtrlPkg::dataT memRdata,
    output logic                   iGrant,
    output logic                   dGrant,
    output logic                   iDone,
    output logic                   dDone,
    output logic                   memStart,
    output logic                   memWe,
    output pipeCtrlPkg::addrT      memAddr,
    output pipeCtrlPkg::dataT      memWdata,
    output pipeCtrlPkg::dataT      iRdata,
    output pipeCtrlPkg::dataT      dRdata
);
    import pipeCtrlPkg::*;

    requesterT owner;

    assign dGrant   = dMemReq && !memBusy;
    assign iGrant   = iMemReq && !dMemReq && !memBusy; // data wins ties
    assign memStart = iGrant || dGrant;

    always_comb begin
        if (dGrant) begin
            memAddr  = dAddr;
            memWe    = dWe;
            memWdata = dWdata;
        end else begin
            memAddr  = iAddr;
            memWe    = iWe && iGrant; // no stray write strobe
            memWdata = iWdata;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            owner <= instPort;
        end else if (memStart) begin
            owner <= dGrant ? dataPort : instPort;
        end
    end

    // completion goes to the owner only
    assign iDone  = memDone && (owner == instPort);
    assign dDone  = memDone && (owner == dataPort);
    assign iRdata = memRdata;
    assign dRdata = memRdata;

    // single access in flight needs the memory busy right after a start
    memBusyAfterStart: assert property (@(posedge clk) disable iff (!arstN)
        memStart |=> memBusy);

endmodule

`default_nettype wire

// File: sharedMem.sv
/* Single-ported word memory, one access in flight, no byte enables.
   Address bits below the word and above the array depth are ignored. */
`default_nettype none

`include "pipeCtrl_defines.svh"

module sharedMem (
    input  wire                    clk,
    input  wire                    arstN,
    input  wire                    start,
    input  wire                    we,
    input  wire pipeCtrlPkg::addrT addr,
    input  wire pipeCtrlPkg::dataT wdata,
    output logic                   busy,
    output logic                   done,
    output pipeCtrlPkg::dataT      rdata
);
    import pipeCtrlPkg::*;

    localparam int ByteOffset = $clog2(`DATA_WIDTH / 8);
    localparam int CntWidth   = $clog2(`MEM_LATENCY + 1);

    dataT                mem [`MEM_WORDS];
    wordIdxT             idxReg;
    dataT                wdataReg;
    logic                weReg;
    logic [CntWidth-1:0] cnt;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= CntWidth'(`MEM_LATENCY);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            idxReg   <= addr[ByteOffset +: $bits(wordIdxT)];
            weReg    <= we;
            wdataReg <= wdata;
        end
        if (done && weReg) mem[idxReg] <= wdataReg; // write lands at done
    end

    assign busy  = (cnt != '0);
    assign done  = (cnt == CntWidth'(1));
    assign rdata = mem[idxReg];

    noStartWhileBusy: assert property (@(posedge clk) disable iff (!arstN)
        start |-> !busy);

endmodule

`default_nettype wire

// File: pipeCtrlTop.sv
/* Pipeline control with instruction and data ports on one shared memory.
   The fetch port never writes; port busy feeds back into the stall logic. */
`default_nettype none

module pipeCtrlTop (
    input  wire                    clk,
    input  wire                    arstN,
    input  wire                    flushException,
    input  wire                    iTlbStall,
    input  wire                    dTlbStall,
    input  wire                    dataHazardStall,
    input  wire                    idImmJump,
    input  wire                    branchFailed,
    input  wire                    mulDivBusy,
    input  wire                    memAccessReq,
    input  wire                    mem2StoreReq,
    input  wire                    wbStoreReq,
    input  wire pipeCtrlPkg::addrT memAddr,
    input  wire pipeCtrlPkg::addrT mem2Addr,
    input  wire pipeCtrlPkg::addrT wbAddr,
    input  wire                    fetchReq,
    input  wire                    loadStoreReq,
    input  wire                    dataWe,
    input  wire pipeCtrlPkg::addrT fetchAddr,
    input  wire pipeCtrlPkg::addrT dataAddr,
    input  wire pipeCtrlPkg::dataT dataWdata,
    output logic                   preIfWr,
    output logic                   ifWr,
    output logic                   idWr,
    output logic                   exeWr,
    output logic                   memWr,
    output logic                   mem2Wr,
    output logic                   wbWr,
    output logic                   ifFlush,
    output logic                   idFlush,
    output logic                   exeFlush,
    output logic                   memFlush,
    output logic                   mem2Flush,
    output logic                   wbFlush,
    output logic                   exeDisWr,
    output logic                   memDisWr,
    output logic                   wbDisWr,
    output logic                   fetchValid,
    output logic                   loadValid,
    output pipeCtrlPkg::dataT      fetchData,
    output pipeCtrlPkg::dataT      loadData
);
    import pipeCtrlPkg::*;

    logic iBusy, dBusy, iFlush, dFlush, iReqEnable, dReqEnable, iHold, dHold;
    logic iMemReq, dMemReq, iGrant, dGrant, iDone, dDone, iMemWe, dMemWe;
    logic shStart, shWe, shBusy, shDone;
    addrT iMemAddr, dMemAddr, shAddr;
    dataT iMemWdata, dMemWdata, iRespData, dRespData, shWdata, shRdata;

    pipeControl ctrl (
        .flushException, .iTlbStall, .dTlbStall, .iBusy, .dBusy, .dataHazardStall,
        .idImmJump, .branchFailed, .mulDivBusy, .memAccessReq, .mem2StoreReq,
        .wbStoreReq, .memAddr, .mem2Addr, .wbAddr,
        .preIfWr, .ifWr, .idWr, .exeWr, .memWr, .mem2Wr, .wbWr,
        .ifFlush, .idFlush, .exeFlush, .memFlush, .mem2Flush, .wbFlush,
        .exeDisWr, .memDisWr, .wbDisWr,
        .iFlush, .dFlush, .iReqEnable, .dReqEnable, .iHold, .dHold
    );

    accessPort iPort ( // read-only fetch path
        .clk, .arstN, .req(fetchReq), .we(1'b0), .reqEnable(iReqEnable),
        .flush(iFlush), .hold(iHold), .grant(iGrant), .respDone(iDone),
        .addr(fetchAddr), .wdata('0), .respData(iRespData),
        .memReq(iMemReq), .busy(iBusy), .valid(fetchValid), .memAddr(iMemAddr),
        .memWdata(iMemWdata), .rdata(fetchData), .memWe(iMemWe)
    );

    accessPort dPort (
        .clk, .arstN, .req(loadStoreReq), .we(dataWe), .reqEnable(dReqEnable),
        .flush(dFlush), .hold(dHold), .grant(dGrant), .respDone(dDone),
        .addr(dataAddr), .wdata(dataWdata), .respData(dRespData),
        .memReq(dMemReq), .busy(dBusy), .valid(loadValid), .memAddr(dMemAddr),
        .memWdata(dMemWdata), .rdata(loadData), .memWe(dMemWe)
    );

    memArbiter arb (
        .clk, .arstN, .iMemReq, .dMemReq, .memBusy(shBusy), .memDone(shDone),
        .iWe(iMemWe), .dWe(dMemWe), .iAddr(iMemAddr), .dAddr(dMemAddr),
        .iWdata(iMemWdata), .dWdata(dMemWdata), .memRdata(shRdata),
        .iGrant, .dGrant, .iDone, .dDone, .memStart(shStart), .memWe(shWe),
        .memAddr(shAddr), .memWdata(shWdata), .iRdata(iRespData), .dRdata(dRespData)
    );

    sharedMem mem (
        .clk, .arstN, .start(shStart), .we(shWe), .addr(shAddr), .wdata(shWdata),
        .busy(shBusy), .done(shDone), .rdata(shRdata)
    );

endmodule

`default_nettype wire

// File: tbPipeCtrl.sv
/* Testbench for the pipeline control top level; the run stops at the first error.
   Memory is only read back at addresses the test has stored to first. */
`default_nettype none

`include "pipeCtrl_defines.svh"

module tbPipeCtrl;
    timeunit 1ns;
    timeprecision 100ps;
    import pipeCtrlPkg::*;

    localparam int LineShift    = $clog2(`LINE_BYTES);
    localparam int ByteShift    = $clog2(`DATA_WIDTH / 8);
    localparam int RandomCycles = 300;
    // about 350 cycles of random and directed control tests plus ~15 per access
    localparam int MaxCycles    = 4000;
    localparam logic [15:0] NormalVec   = 16'b1111111_000000_000;
    localparam logic [15:0] ConflictVec = 16'b0000011_000000_000;

    logic clk = 1'b0;
    logic arstN;
    logic flushException, iTlbStall, dTlbStall, dataHazardStall, idImmJump;
    logic branchFailed, mulDivBusy, memAccessReq, mem2StoreReq, wbStoreReq;
    logic fetchReq, loadStoreReq, dataWe;
    addrT memAddr, mem2Addr, wbAddr, fetchAddr, dataAddr;
    dataT dataWdata;
    logic preIfWr, ifWr, idWr, exeWr, memWr, mem2Wr, wbWr;
    logic ifFlush, idFlush, exeFlush, memFlush, mem2Flush, wbFlush;
    logic exeDisWr, memDisWr, wbDisWr, fetchValid, loadValid;
    dataT fetchData, loadData;

    logic [15:0] actCtrl;
    bit          ctrlCheckOn = 1'b0;
    bit          iBusyExp = 1'b0; // port busy as the test expects it
    bit          dBusyExp = 1'b0;
    string       testName = "reset";
    int          cycleCount = 0;
    dataT        mirror [`MEM_WORDS];

    pipeCtrlTop dut (.*);

    always #4 clk = ~clk;

    assign actCtrl = {preIfWr, ifWr, idWr, exeWr, memWr, mem2Wr, wbWr,
                      ifFlush, idFlush, exeFlush, memFlush, mem2Flush, wbFlush,
                      exeDisWr, memDisWr, wbDisWr};

    function automatic wordIdxT wordOf(input addrT a);
        return a[ByteShift +: $bits(wordIdxT)];
    endfunction

    function automatic bit sameLine(input addrT a, input addrT b);
        return (a >> LineShift) == (b >> LineShift);
    endfunction

    // stage write enables, then stage flushes, then disable-writes
    function automatic logic [15:0] refCtrl(input bit exc, input bit iTlb, input bit dTlb,
                                            input bit iBusy, input bit dBusy, input bit hazard,
                                            input bit jump, input bit branch, input bit mulDiv,
                                            input bit conflict);
        logic [6:0] wr;
        logic [5:0] fl;
        logic [2:0] dis;
        wr  = '1;
        fl  = '0;
        dis = '0;
        if (exc) begin
            fl  = 6'b111100; // if through mem
            dis = 3'b110;
        end else if (iTlb || iBusy || dTlb || dBusy) begin
            wr  = '0;
            dis = '1;
        end else if (conflict) begin
            wr  = 7'b0000011; // mem2 and wb drain
        end else if (hazard) begin
            wr  = 7'b0001111;
            fl  = 6'b001000;
        end else if (jump) begin
            fl  = 6'b100000;
        end else if (branch) begin
            fl  = 6'b110000;
        end else if (mulDiv) begin
            wr  = '0;
            dis = '1;
        end
        return {wr, fl, dis};
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkCtrl(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp)
            failRun($sformatf("mismatch %s expected %b actual %b", name, exp, act));
    endtask

    task automatic checkData(input string name, input dataT exp, input dataT act);
        if (act !== exp)
            failRun($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    // control outputs against the reference on every cycle
    always @(negedge clk) begin
        bit conflict;
        conflict = memAccessReq && ((mem2StoreReq && sameLine(memAddr, mem2Addr)) ||
                                    (wbStoreReq && sameLine(memAddr, wbAddr)));
        if (ctrlCheckOn)
            checkCtrl(testName, refCtrl(flushException, iTlbStall, dTlbStall, iBusyExp,
                      dBusyExp, dataHazardStall, idImmJump, branchFailed, mulDivBusy,
                      conflict), actCtrl);
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= MaxCycles)
            failRun("timeout: the run did not finish within the cycle limit");
    end

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic setHazards(input logic [6:0] bits);
        {flushException, iTlbStall, dTlbStall, dataHazardStall, idImmJump, branchFailed,
         mulDivBusy} = bits;
    endtask

    task automatic clearInputs();
        setHazards('0);
        {memAccessReq, mem2StoreReq, wbStoreReq} = '0;
        memAddr      = '0;
        mem2Addr     = '0;
        wbAddr       = '0;
        fetchReq     = 1'b0;
        loadStoreReq = 1'b0;
        dataWe       = 1'b0;
        fetchAddr    = '0;
        dataAddr     = '0;
        dataWdata    = '0;
    endtask

    task automatic randomHazards(input int count);
        repeat (count) begin
            setHazards(7'($urandom & $urandom)); // each source about 1 in 4
            {memAccessReq, mem2StoreReq, wbStoreReq} = 3'($urandom);
            memAddr  = $urandom;
            mem2Addr = ($urandom % 2) ? (memAddr ^ ($urandom % `LINE_BYTES)) : $urandom;
            wbAddr   = ($urandom % 2) ? (memAddr ^ ($urandom % `LINE_BYTES)) : $urandom;
            nextCycle();
        end
    endtask

    task automatic lineConflictCase(input string name, input bit acc, input bit st2,
                                    input bit stWb, input addrT a, input addrT a2,
                                    input addrT aWb, input bit expectConflict);
        testName     = name;
        memAccessReq = acc;
        mem2StoreReq = st2;
        wbStoreReq   = stWb;
        memAddr      = a;
        mem2Addr     = a2;
        wbAddr       = aWb;
        #1;
        checkCtrl(name, expectConflict ? ConflictVec : NormalVec, actCtrl);
        nextCycle();
    endtask

    task automatic storeWord(input addrT a, input dataT d);
        loadStoreReq = 1'b1;
        dataWe       = 1'b1;
        dataAddr     = a;
        dataWdata    = d;
        nextCycle();
        loadStoreReq = 1'b0;
        dataWe       = 1'b0;
        dBusyExp     = 1'b1;
        while (!loadValid) nextCycle();
        dBusyExp = 1'b0;
        mirror[wordOf(a)] = d;
        nextCycle(); // port back to idle
    endtask

    task automatic fetchWord(input addrT a);
        fetchReq  = 1'b1;
        fetchAddr = a;
        nextCycle();
        fetchReq = 1'b0;
        iBusyExp = 1'b1;
        while (!fetchValid) nextCycle();
        iBusyExp = 1'b0;
        checkData(testName, mirror[wordOf(a)], fetchData);
        nextCycle();
    endtask

    task automatic fetchAndLoad(input addrT fa, input addrT la);
        int cyc = 1;
        int fetchCyc = -1;
        int loadCyc = -1;
        fetchReq     = 1'b1;
        fetchAddr    = fa;
        loadStoreReq = 1'b1;
        dataAddr     = la;
        nextCycle();
        fetchReq     = 1'b0;
        loadStoreReq = 1'b0;
        iBusyExp     = 1'b1;
        dBusyExp     = 1'b1;
        while (fetchCyc < 0 || loadCyc < 0) begin
            if (loadCyc < 0 && loadValid) begin
                loadCyc  = cyc;
                dBusyExp = 1'b0;
                checkData({testName, " load"}, mirror[wordOf(la)], loadData);
            end
            if (fetchCyc < 0 && fetchValid) begin
                fetchCyc = cyc;
                iBusyExp = 1'b0;
                checkData({testName, " fetch"}, mirror[wordOf(fa)], fetchData);
            end
            if (fetchCyc < 0 || loadCyc < 0) begin
                nextCycle();
                cyc++;
            end
        end
        if (loadCyc > fetchCyc)
            failRun("load result arrived after the concurrent fetch result");
        nextCycle();
    endtask

    task automatic jumpCancelsFetch(input addrT a);
        fetchReq  = 1'b1;
        fetchAddr = a;
        nextCycle();
        fetchReq = 1'b0;
        iBusyExp = 1'b1;
        nextCycle();
        idImmJump = 1'b1; // fetch now in flight
        for (int cyc = 2; cyc < 12; cyc++) begin
            iBusyExp = (cyc <= `MEM_LATENCY + 1); // uncontended access
            if (fetchValid)
                failRun("fetch result was shown after the jump flushed it");
            nextCycle();
        end
        idImmJump = 1'b0;
        nextCycle();
    endtask

    initial begin
        addrT addrs [4];
        addrs = '{32'h0000_0040, 32'h0000_0044, 32'h0000_0180, 32'h0000_03fc};
        void'($urandom(75227));
        arstN = 1'b0;
        clearInputs();
        repeat (2) @(posedge clk);
        #1;
        arstN       = 1'b1;
        ctrlCheckOn = 1'b1;
        testName    = "after reset";
        if (fetchValid || loadValid)
            failRun("a port shows a valid result right after reset");
        repeat (3) nextCycle();

        testName = "exception over all";
        setHazards(7'h7f);
        {memAccessReq, mem2StoreReq} = 2'b11;
        nextCycle();
        testName = "jump before mispredict";
        clearInputs();
        setHazards(7'b0000110);
        nextCycle();
        testName = "random hazards";
        randomHazards(RandomCycles);
        clearInputs();

        lineConflictCase("conflict mem2", 1, 1, 0, 32'h1204, 32'h120c, 32'h0, 1);
        lineConflictCase("conflict wb", 1, 0, 1, 32'h1204, 32'h0, 32'h1200, 1);
        lineConflictCase("tags differ", 1, 1, 1, 32'h1204, 32'h1214, 32'h11f0, 0);
        lineConflictCase("store inactive", 1, 0, 0, 32'h1204, 32'h1204, 32'h1204, 0);
        lineConflictCase("no mem access", 0, 1, 1, 32'h1204, 32'h1204, 32'h1204, 0);
        clearInputs();
        nextCycle();

        testName = "store then fetch";
        foreach (addrs[i]) begin
            storeWord(addrs[i], $urandom);
            fetchWord(addrs[i]);
        end
        testName = "concurrent access";
        fetchAndLoad(addrs[0], addrs[1]);
        fetchAndLoad(addrs[3], addrs[2]);
        testName = "jump cancels fetch";
        jumpCancelsFetch(addrs[2]);
        testName = "fetch after jump";
        fetchWord(addrs[1]);
        repeat (2) nextCycle();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: pipeCtrl.f
+incdir+.
pipeCtrlPkg.sv
pipeControl.sv
accessPort.sv
memArbiter.sv
sharedMem.sv
pipeCtrlTop.sv
tbPipeCtrl.sv
